// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [2:0] funct3_t;

  // ----------------------------------------
  // Major opcodes
  // ----------------------------------------
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // ALU groups, shared by OP and OP_IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  localparam instr_t EBREAK_INSTR = 32'h0010_0073;

endpackage

// File: design/rv_core_pkg.sv
package rv_core_pkg;

  import rv_isa_pkg::*;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // ----------------------------------------
  // ALU and write-back selects
  // ----------------------------------------
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4
  } wb_src_t;

  // Per-instruction control, produced by the decoder
  typedef struct packed {
    logic    reg_write;
    logic    mem_write;
    logic    alu_a_pc;
    logic    alu_a_zero;
    logic    alu_b_imm;
    alu_op_t alu_op;
    wb_src_t wb_src;
    logic    is_branch;
    logic    is_jump;
    logic    is_jalr;
    logic    is_ebreak;
    funct3_t funct3;
  } ctrl_t;

endpackage

// File: design/rv_decoder.sv
module rv_decoder
  import rv_isa_pkg::*, rv_core_pkg::*;
(
  input  instr_t   instr,
  output ctrl_t    ctrl,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output word_t    imm
);

  opcode_t opcode;
  funct3_t funct3;
  logic    funct7_b5;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_u;
  word_t   imm_j;

  // Map funct3 to an ALU op, alt picks SUB or SRA
  function automatic alu_op_t alu_op_of(funct3_t f3, logic alt);
    case (f3)
      F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      default:    return ALU_AND;
    endcase
  endfunction

  assign opcode    = opcode_t'(instr[6:0]);
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];
  assign rd        = instr[11:7];
  assign rs1       = instr[19:15];
  assign rs2       = instr[24:20];

  // ----------------------------------------
  // Immediates, all sign-extended
  // ----------------------------------------
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // ----------------------------------------
  // Control
  // ----------------------------------------
  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    ctrl.wb_src = WB_ALU;
    ctrl.funct3 = funct3;
    imm         = imm_i;

    case (opcode)
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_op_of(funct3, funct7_b5);
      end
      OPC_OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        // Only shifts use funct7, ADDI never turns into a subtract
        ctrl.alu_op    = alu_op_of(funct3, funct7_b5 && funct3 == F3_SRL_SRA);
      end
      OPC_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.wb_src    = WB_LOAD;
      end
      OPC_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        imm            = imm_s;
      end
      OPC_BRANCH: begin
        ctrl.is_branch = 1'b1;
        imm            = imm_b;
      end
      OPC_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.wb_src    = WB_PC4;
        imm            = imm_j;
      end
      OPC_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.wb_src    = WB_PC4;
      end
      OPC_LUI: begin
        ctrl.reg_write  = 1'b1;
        ctrl.alu_a_zero = 1'b1;
        ctrl.alu_b_imm  = 1'b1;
        imm             = imm_u;
      end
      OPC_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_a_pc  = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        imm            = imm_u;
      end
      OPC_SYSTEM: begin
        ctrl.is_ebreak = (instr == EBREAK_INSTR);
      end
      default: begin
        // Unknown opcode, no writes
      end
    endcase
  end

endmodule

// File: design/rv_regfile.sv
module rv_regfile
  import rv_isa_pkg::*, rv_core_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     we,
  input  reg_idx_t rd,
  input  word_t    rd_data
);

  // x1..x31, x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: design/rv_alu.sv
module rv_alu
  import rv_core_pkg::*;
(
  input  ctrl_t ctrl,
  input  addr_t pc,
  input  word_t rs1_data,
  input  word_t rs2_data,
  input  word_t imm,
  output word_t result
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;

  // ----------------------------------------
  // Operand select
  // ----------------------------------------
  always_comb begin
    if (ctrl.alu_a_zero) begin
      op_a = '0;
    end else if (ctrl.alu_a_pc) begin
      op_a = pc;
    end else begin
      op_a = rs1_data;
    end
  end

  assign op_b  = ctrl.alu_b_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  // ----------------------------------------
  // Operations
  // ----------------------------------------
  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  result = op_a + op_b;
      ALU_SUB:  result = op_a - op_b;
      ALU_AND:  result = op_a & op_b;
      ALU_OR:   result = op_a | op_b;
      ALU_XOR:  result = op_a ^ op_b;
      ALU_SLL:  result = op_a << shamt;
      ALU_SRL:  result = op_a >> shamt;
      ALU_SRA:  result = word_t'($signed(op_a) >>> shamt);
      // Compares give 1 or 0
      ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: result = {31'b0, op_a < op_b};
      default:  result = '0;
    endcase
  end

endmodule

// File: design/rv_pc_unit.sv
module rv_pc_unit
  import rv_isa_pkg::*, rv_core_pkg::*;
#(
  parameter addr_t RESET_PC = 32'h0000_0000
) (
  input  logic  clk,
  input  logic  arst_n,
  input  ctrl_t ctrl,
  input  word_t rs1_data,
  input  word_t rs2_data,
  input  word_t imm,
  input  word_t alu_result,
  output addr_t pc,
  output addr_t pc_plus4,
  output logic  halted
);

  logic  eq;
  logic  lt_s;
  logic  lt_u;
  logic  taken;
  addr_t target;
  addr_t next_pc;

  // ----------------------------------------
  // Branch compare
  // ----------------------------------------
  assign eq   = (rs1_data == rs2_data);
  assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign lt_u = (rs1_data < rs2_data);

  always_comb begin
    case (ctrl.funct3)
      F3_BEQ:  taken = eq;
      F3_BNE:  taken = !eq;
      F3_BLT:  taken = lt_s;
      F3_BGE:  taken = !lt_s;
      F3_BLTU: taken = lt_u;
      F3_BGEU: taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

  // JALR drops bit 0 of rs1 plus offset
  assign target   = ctrl.is_jalr ? {alu_result[31:1], 1'b0} : pc + imm;
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    if (halted || ctrl.is_ebreak) begin
      next_pc = pc;
    end else if (ctrl.is_jump || (ctrl.is_branch && taken)) begin
      next_pc = target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else begin
      pc     <= next_pc;
      halted <= halted || ctrl.is_ebreak;
    end
  end

endmodule

// File: design/rv_core.sv
module rv_core
  import rv_isa_pkg::*, rv_core_pkg::*;
#(
  parameter addr_t RESET_PC = 32'h0000_0000
) (
  input  logic   clk,
  input  logic   arst_n,
  output addr_t  imem_raddr,
  input  instr_t imem_rdata,
  output addr_t  dmem_addr,
  input  word_t  dmem_rdata,
  output logic   dmem_we,
  output word_t  dmem_wdata,
  output logic   ebreak
);

  ctrl_t    ctrl;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    alu_result;
  word_t    rd_data;
  addr_t    pc;
  addr_t    pc_plus4;
  logic     halted;
  logic     reg_we;

  rv_decoder decoder0 (
    .instr (imem_rdata),
    .ctrl  (ctrl),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd),
    .imm   (imm)
  );

  rv_regfile regfile0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (reg_we),
    .rd       (rd),
    .rd_data  (rd_data)
  );

  rv_alu alu0 (
    .ctrl     (ctrl),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .result   (alu_result)
  );

  rv_pc_unit #(
    .RESET_PC (RESET_PC)
  ) pc_unit0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .ctrl       (ctrl),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .alu_result (alu_result),
    .pc         (pc),
    .pc_plus4   (pc_plus4),
    .halted     (halted)
  );

  // ----------------------------------------
  // Write-back and memory ports
  // ----------------------------------------
  always_comb begin
    case (ctrl.wb_src)
      WB_LOAD: rd_data = dmem_rdata;
      WB_PC4:  rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  assign reg_we     = ctrl.reg_write && !halted;
  assign imem_raddr = pc;
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  // No stray store while in reset or after halt
  assign dmem_we    = ctrl.mem_write && arst_n && !halted;
  assign ebreak     = halted;

endmodule

// File: tests/tb_clock.sv
module tb_clock #(
  parameter int PERIOD_NS = 4
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

// File: tests/rv_core_tb.sv
module rv_core_tb
  import rv_isa_pkg::*, rv_core_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int      CLK_PERIOD_NS = 4;
  localparam int      RESET_CYCLES  = 10;
  localparam int      DRIVE_DELAY   = 1;
  localparam int      NUM_IN        = 8;
  localparam int      IN_BASE       = 'h100;
  localparam addr_t   OUT_BASE      = 32'h0000_0200;
  localparam word_t   SEED          = 32'd87;
  localparam funct3_t F3_WORD       = 3'b010;

  typedef struct packed {
    addr_t addr;
    word_t data;
  } store_t;

  logic   clk;
  logic   arst_n;
  addr_t  imem_raddr;
  instr_t imem_rdata;
  addr_t  dmem_addr;
  word_t  dmem_rdata;
  logic   dmem_we;
  word_t  dmem_wdata;
  logic   ebreak;

  instr_t imem [0:255];
  word_t  dmem [0:255];
  word_t  xval [0:31];
  store_t expect_q [$];
  word_t  lcg_state;
  addr_t  out_addr;
  int     prog_len;
  logic   prog_ready = 1'b0;
  int     checks;
  int     mismatches;
  int     failures;

  tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) clock0 (.clk(clk));

  rv_core #(.RESET_PC(32'h0000_0000)) dut0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_we    (dmem_we),
    .dmem_wdata (dmem_wdata),
    .ebreak     (ebreak)
  );

  // Both memories answer in the same cycle
  assign imem_rdata = imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  // ----------------------------------------
  // Encoders and reference model
  // ----------------------------------------
  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic instr_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3,
                                   reg_idx_t rd, opcode_t op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic instr_t enc_i(logic [11:0] imm, reg_idx_t rs1, funct3_t f3, reg_idx_t rd,
                                   opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instr_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic instr_t enc_b(logic [12:0] off, reg_idx_t rs1, reg_idx_t rs2, funct3_t f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic instr_t enc_u(logic [19:0] imm, reg_idx_t rd, opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic instr_t enc_j(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // RV32I result of an OP or OP_IMM group with alt as funct7 bit 5
  function automatic word_t expected_alu(funct3_t f3, logic alt, word_t a, word_t b);
    case (f3)
      F3_ADD_SUB: return alt ? a - b : a + b;
      F3_SLL:     return a << b[4:0];
      F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
      F3_XOR:     return a ^ b;
      F3_SRL_SRA: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      F3_OR:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(funct3_t f3, word_t a, word_t b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      F3_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic addr_t next_addr();
    return addr_t'(prog_len * 4);
  endfunction

  // ----------------------------------------
  // Program builder
  // ----------------------------------------
  task automatic emit(instr_t i);
    imem[prog_len] = i;
    prog_len++;
  endtask

  // Store rs to the next output slot and queue the value it must hold
  task automatic store_expect(reg_idx_t rs, word_t value);
    store_t s;
    emit(enc_s(12'(out_addr), rs, 5'd0, F3_WORD));
    s.addr = out_addr;
    s.data = value;
    expect_q.push_back(s);
    out_addr = out_addr + 32'd4;
  endtask

  task automatic alu_reg_case(funct3_t f3, logic alt, reg_idx_t ra, reg_idx_t rb);
    emit(enc_r(alt ? 7'b0100000 : 7'b0000000, rb, ra, f3, 5'd10, OPC_OP));
    store_expect(5'd10, expected_alu(f3, alt, xval[ra], xval[rb]));
  endtask

  task automatic alu_imm_case(funct3_t f3, logic alt, reg_idx_t ra);
    word_t       r;
    logic [11:0] imm;
    word_t       b;
    r = lcg_next();
    if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
      imm = {1'b0, alt, 5'b0, r[4:0]};
      b   = {27'b0, r[4:0]};
    end else begin
      imm = r[11:0];
      b   = {{20{r[11]}}, r[11:0]};
    end
    emit(enc_i(imm, ra, f3, 5'd10, OPC_OP_IMM));
    store_expect(5'd10, expected_alu(f3, alt, xval[ra], b));
  endtask

  // x10 keeps 1 only when the branch skips the clearing ADDI
  task automatic branch_case(funct3_t f3, reg_idx_t ra, reg_idx_t rb);
    emit(enc_i(12'd1, 5'd0, F3_ADD_SUB, 5'd10, OPC_OP_IMM));
    emit(enc_b(13'd8, ra, rb, f3));
    emit(enc_i(12'd0, 5'd0, F3_ADD_SUB, 5'd10, OPC_OP_IMM));
    store_expect(5'd10, branch_taken(f3, xval[ra], xval[rb]) ? 32'd1 : 32'd0);
  endtask

  task automatic build_program();
    word_t    r;
    addr_t    a;
    int       k;
    reg_idx_t pair_a [0:2];
    reg_idx_t pair_b [0:2];
    funct3_t  br_f3 [0:5];
    pair_a    = '{5'd1, 5'd2, 5'd1};
    pair_b    = '{5'd2, 5'd3, 5'd9};
    br_f3     = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    lcg_state = SEED;
    out_addr  = OUT_BASE;
    prog_len  = 0;
    k         = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = EBREAK_INSTR;
      dmem[i] = (word_t'(i) * 32'h0001_0003) ^ 32'h5a5a_0000;
    end
    for (int i = 0; i < 32; i++) begin
      xval[i] = '0;
    end
    // Input words with x1 negative and x2 positive
    for (int i = 0; i < NUM_IN; i++) begin
      r = lcg_next();
      if (i == 0)
        r[31] = 1'b1;
      if (i == 1)
        r[31] = 1'b0;
      dmem[IN_BASE / 4 + i] = r;
      xval[i + 1] = r;
      emit(enc_i(12'(IN_BASE + 4 * i), 5'd0, F3_WORD, reg_idx_t'(i + 1), OPC_LOAD));
    end
    emit(enc_r(7'b0, 5'd0, 5'd1, F3_ADD_SUB, 5'd9, OPC_OP));
    xval[9] = xval[1];

    for (int f = 0; f < 8; f++) begin
      alu_reg_case(funct3_t'(f), 1'b0, reg_idx_t'(1 + k % NUM_IN),
                   reg_idx_t'(1 + (k + 3) % NUM_IN));
      alu_imm_case(funct3_t'(f), 1'b0, reg_idx_t'(1 + (k + 5) % NUM_IN));
      k++;
      if (f == 0 || f == 5)
        alu_reg_case(funct3_t'(f), 1'b1, 5'd1, 5'd4);
    end
    alu_imm_case(F3_SRL_SRA, 1'b1, 5'd1);

    r = lcg_next();
    emit(enc_u(r[19:0], 5'd10, OPC_LUI));
    store_expect(5'd10, {r[19:0], 12'b0});
    r = lcg_next();
    a = next_addr();
    emit(enc_u(r[19:0], 5'd10, OPC_AUIPC));
    store_expect(5'd10, a + {r[19:0], 12'b0});

    for (int i = 0; i < 6; i++) begin
      for (int j = 0; j < 3; j++) begin
        branch_case(br_f3[i], pair_a[j], pair_b[j]);
      end
    end

    // JAL over an EBREAK to a target that stores the x12 marker first
    r = lcg_next();
    emit(enc_i({1'b0, r[10:0]}, 5'd0, F3_ADD_SUB, 5'd12, OPC_OP_IMM));
    a = next_addr();
    emit(enc_j(21'd8, 5'd11));
    emit(EBREAK_INSTR);
    store_expect(5'd12, {21'b0, r[10:0]});
    store_expect(5'd11, a + 32'd4);

    // JALR from an odd base lands at base + 4 with bit 0 cleared
    r = lcg_next();
    emit(enc_i({1'b0, r[10:0]}, 5'd0, F3_ADD_SUB, 5'd12, OPC_OP_IMM));
    a = next_addr();
    emit(enc_i(12'(a + 32'd9), 5'd0, F3_ADD_SUB, 5'd13, OPC_OP_IMM));
    emit(enc_i(12'd4, 5'd13, 3'b000, 5'd14, OPC_JALR));
    emit(EBREAK_INSTR);
    store_expect(5'd12, {21'b0, r[10:0]});
    store_expect(5'd14, a + 32'd8);

    emit(enc_i(12'h5a5, 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM));
    store_expect(5'd0, '0);
    emit(enc_r(7'b0, 5'd2, 5'd1, F3_ADD_SUB, 5'd0, OPC_OP));
    store_expect(5'd0, '0);

    emit(EBREAK_INSTR);
    // Must never execute
    emit(enc_s(12'h3f0, 5'd1, 5'd0, F3_WORD));
    prog_ready = 1'b1;
  endtask

  // ----------------------------------------
  // Checks and port monitor
  // ----------------------------------------
  task automatic check_addr(addr_t got, addr_t exp, string what);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s address %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(word_t got, word_t exp, string what);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s data %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic port_monitor();
    store_t exp_s;
    int     idx;
    idx = 0;
    forever begin
      @(posedge clk);
      // Every fetch address must be word aligned
      if (arst_n === 1'b1 && imem_raddr[1:0] !== 2'b00) begin
        failures++;
        $display("Error at %0t: misaligned fetch from %h", $time, imem_raddr);
      end
      if (dmem_we === 1'b1) begin
        if (ebreak === 1'b1) begin
          failures++;
          $display("Error at %0t: store to %h after ebreak", $time, dmem_addr);
        end else if (expect_q.size() == 0) begin
          failures++;
          $display("Error at %0t: unexpected store to %h", $time, dmem_addr);
        end else begin
          exp_s = expect_q.pop_front();
          check_addr(dmem_addr, exp_s.addr, $sformatf("store %0d", idx));
          check_word(dmem_wdata, exp_s.data, $sformatf("store %0d", idx));
        end
        dmem[dmem_addr[9:2]] = dmem_wdata;
        idx++;
      end
    end
  endtask

  initial begin
    arst_n     = 1'b0;
    checks     = 0;
    mismatches = 0;
    failures   = 0;
    build_program();
    fork
      port_monitor();
    join_none
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY arst_n = 1'b1;
    wait (ebreak === 1'b1);
    if (expect_q.size() != 0) begin
      failures++;
      $display("Error: %0d expected stores missing when ebreak rose", expect_q.size());
    end
    // A few more cycles to catch a store after the halt
    repeat (4) @(posedge clk);
    $display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (prog_ready === 1'b1);
    #((RESET_CYCLES + prog_len + 20) * CLK_PERIOD_NS);
    $display("Timeout: ebreak never rose within %0d cycles", RESET_CYCLES + prog_len + 20);
    $display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: rv_core.f
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_pc_unit.sv
design/rv_core.sv
tests/tb_clock.sv
tests/rv_core_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := rv_core_tb
FILELIST  := rv_core.f
PASS_MSG  := TEST OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
